//--- axi_chan_pkg.sv
// AXI4 channel payloads and request/response bundles shared by the isolation stage.
// Import inside a module body, or use scoped names in port lists.
`default_nettype none

package axi_chan_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned LenWidth  = 8;

  ////////////////////
  // Channel payloads
  ////////////////////

  // Write address, only id, addr and len are carried
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } aw_chan_t;

  // Read address, same layout but kept as its own type
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } w_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [1:0]         resp;
  } b_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } r_chan_t;

  ////////////////////
  // Bundles
  ////////////////////

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

endpackage

`default_nettype wire

//--- isolate_pkg.sv
// Isolation state encoding and pending-transaction counter definitions.
// Used by the address path controllers and the W burst tracker.
`default_nettype none

package isolate_pkg;

  // Open transactions allowed per path before new requests stall
  localparam int unsigned NumPending = 4;

  // Enough bits to hold 0 up to NumPending
  localparam int unsigned CntWidth = $clog2(NumPending + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  // Per-path isolation state
  typedef enum logic [1:0] {
    NORMAL,
    HOLD,
    DRAIN,
    ISOLATE
  } iso_state_e;

endpackage

`default_nettype wire

//--- isolate_chan_ctrl.sv
// Isolation control for one AXI address path (AW or AR).
// Tracks open transactions and cuts the request once drained and isolated.
`timescale 1ns/1ps
`default_nettype none

module isolate_chan_ctrl #(
  parameter type chan_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  isolate_i,
  input  chan_t slv_chan_i,
  input  logic  slv_valid_i,
  output logic  slv_ready_o,
  output chan_t mst_chan_o,
  output logic  mst_valid_o,
  input  logic  mst_ready_i,
  input  logic  done_i,
  output logic  fire_o,
  output logic  isolated_o
);

  import isolate_pkg::*;

  iso_state_e state_q, state_d;
  cnt_t       cnt_q, cnt_d;
  logic       at_limit;

  // No more room for open transactions on this path
  assign at_limit = (cnt_q >= cnt_t'(NumPending));

  ////////////////////
  // Request path and next state
  ////////////////////

  always_comb begin
    state_d     = state_q;
    mst_chan_o  = slv_chan_i;
    mst_valid_o = slv_valid_i;
    slv_ready_o = mst_ready_i;
    unique case (state_q)
      NORMAL: begin
        if (at_limit) begin
          // Stall both sides until a completion frees a slot
          mst_valid_o = 1'b0;
          slv_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = DRAIN;
          end
        end else if (slv_valid_i && !mst_ready_i) begin
          // Request already counted, keep it alive until accepted
          state_d = HOLD;
        end else if (isolate_i) begin
          state_d = DRAIN;
        end
      end
      HOLD: begin
        // AXI forbids withdrawing valid, so force it regardless of the manager
        mst_valid_o = 1'b1;
        if (mst_ready_i) begin
          state_d = isolate_i ? DRAIN : NORMAL;
        end
      end
      DRAIN: begin
        mst_chan_o  = '0;
        mst_valid_o = 1'b0;
        slv_ready_o = 1'b0;
        // Wait for all open responses
        if (cnt_q == '0) begin
          state_d = ISOLATE;
        end
      end
      ISOLATE: begin
        mst_chan_o  = '0;
        mst_valid_o = 1'b0;
        slv_ready_o = 1'b0;
        if (!isolate_i) begin
          state_d = NORMAL;
        end
      end
      default: begin
        state_d = ISOLATE;
      end
    endcase
  end

  // A request is counted once, at its first master-side valid in NORMAL
  assign fire_o     = (state_q == NORMAL) && mst_valid_o;
  assign isolated_o = (state_q == ISOLATE);

  ////////////////////
  // Pending counter
  ////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (fire_o && !done_i) begin
      cnt_d = cnt_q + cnt_t'(1);
    end else if (!fire_o && done_i) begin
      cnt_d = cnt_q - cnt_t'(1);
    end
    // Both at once leaves the count unchanged
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Come out of reset isolated and idle
      state_q <= ISOLATE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- isolate_w_tracker.sv
// Tracks write bursts whose W data is still owed and gates the W channel.
// Fed with the AW fire pulse of the write address controller.
`timescale 1ns/1ps
`default_nettype none

module isolate_w_tracker (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  aw_fire_i,
  input  axi_chan_pkg::w_chan_t slv_w_i,
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  output axi_chan_pkg::w_chan_t mst_w_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i
);

  import isolate_pkg::*;

  cnt_t cnt_q;
  logic connect_w;
  logic last_beat;

  // W may flow once an AW has opened a burst, including the same cycle
  assign connect_w = (cnt_q != '0) || aw_fire_i;

  assign mst_w_o       = connect_w ? slv_w_i : '0;
  assign mst_w_valid_o = connect_w && slv_w_valid_i;
  assign slv_w_ready_o = connect_w && mst_w_ready_i;

  // Closing beat of a burst on the master side
  assign last_beat = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  // Never exceeds the AW count, so the path counter width suffices
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (aw_fire_i && !last_beat) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end else if (!aw_fire_i && last_beat) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- axi_isolate.sv
// AXI4 isolation stage between a manager-facing slave port and a subordinate-facing master port.
// Raise isolate_i to drain open transactions; isolated_o reports both paths cut.
`timescale 1ns/1ps
`default_nettype none

module axi_isolate (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   isolate_i,
  output logic                   isolated_o,
  input  axi_chan_pkg::axi_req_t slv_req_i,
  output axi_chan_pkg::axi_rsp_t slv_rsp_o,
  output axi_chan_pkg::axi_req_t mst_req_o,
  input  axi_chan_pkg::axi_rsp_t mst_rsp_i
);

  import axi_chan_pkg::*;

  aw_chan_t mst_aw;
  logic     mst_aw_valid, slv_aw_ready, aw_fire, aw_done, aw_isolated;
  ar_chan_t mst_ar;
  logic     mst_ar_valid, slv_ar_ready, ar_done, ar_isolated;
  w_chan_t  mst_w;
  logic     mst_w_valid, slv_w_ready;
  logic     mst_b_ready, mst_r_ready;

  // Ready toward the subordinate is cut while the path is isolated
  assign mst_b_ready = aw_isolated ? 1'b0 : slv_req_i.b_ready;
  assign mst_r_ready = ar_isolated ? 1'b0 : slv_req_i.r_ready;

  // Completions as seen on the master side
  assign aw_done = mst_rsp_i.b_valid && mst_b_ready;
  assign ar_done = mst_rsp_i.r_valid && mst_r_ready && mst_rsp_i.r.last;

  ////////////////////
  // Address paths
  ////////////////////

  isolate_chan_ctrl #(
    .chan_t ( aw_chan_t )
  ) u_aw_ctrl (
    .clk_i       ( clk_i              ),
    .rst_i       ( rst_i              ),
    .isolate_i   ( isolate_i          ),
    .slv_chan_i  ( slv_req_i.aw       ),
    .slv_valid_i ( slv_req_i.aw_valid ),
    .slv_ready_o ( slv_aw_ready       ),
    .mst_chan_o  ( mst_aw             ),
    .mst_valid_o ( mst_aw_valid       ),
    .mst_ready_i ( mst_rsp_i.aw_ready ),
    .done_i      ( aw_done            ),
    .fire_o      ( aw_fire            ),
    .isolated_o  ( aw_isolated        )
  );

  // Read fire pulse has no consumer
  isolate_chan_ctrl #(
    .chan_t ( ar_chan_t )
  ) u_ar_ctrl (
    .clk_i       ( clk_i              ),
    .rst_i       ( rst_i              ),
    .isolate_i   ( isolate_i          ),
    .slv_chan_i  ( slv_req_i.ar       ),
    .slv_valid_i ( slv_req_i.ar_valid ),
    .slv_ready_o ( slv_ar_ready       ),
    .mst_chan_o  ( mst_ar             ),
    .mst_valid_o ( mst_ar_valid       ),
    .mst_ready_i ( mst_rsp_i.ar_ready ),
    .done_i      ( ar_done            ),
    .fire_o      (                    ),
    .isolated_o  ( ar_isolated        )
  );

  // W follows the AW path
  isolate_w_tracker u_w_tracker (
    .clk_i         ( clk_i             ),
    .rst_i         ( rst_i             ),
    .aw_fire_i     ( aw_fire           ),
    .slv_w_i       ( slv_req_i.w       ),
    .slv_w_valid_i ( slv_req_i.w_valid ),
    .slv_w_ready_o ( slv_w_ready       ),
    .mst_w_o       ( mst_w             ),
    .mst_w_valid_o ( mst_w_valid       ),
    .mst_w_ready_i ( mst_rsp_i.w_ready )
  );

  ////////////////////
  // Bundle assembly
  ////////////////////

  always_comb begin
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = mst_w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    mst_req_o.ar       = mst_ar;
    mst_req_o.ar_valid = mst_ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
    // Responses are zeroed toward the manager once the path is isolated
    slv_rsp_o.aw_ready = slv_aw_ready;
    slv_rsp_o.w_ready  = slv_w_ready;
    slv_rsp_o.b        = aw_isolated ? '0 : mst_rsp_i.b;
    slv_rsp_o.b_valid  = aw_isolated ? 1'b0 : mst_rsp_i.b_valid;
    slv_rsp_o.ar_ready = slv_ar_ready;
    slv_rsp_o.r        = ar_isolated ? '0 : mst_rsp_i.r;
    slv_rsp_o.r_valid  = ar_isolated ? 1'b0 : mst_rsp_i.r_valid;
  end

  assign isolated_o = aw_isolated && ar_isolated;

endmodule

`default_nettype wire

//--- axi_isolate_asserts.sv
// Assertions on one address path controller of the isolation stage.
// Bound to every isolate_chan_ctrl instance by the bind at the end of this file.
`timescale 1ns/1ps
`default_nettype none

module axi_isolate_asserts (
  input logic                clk_i,
  input logic                rst_i,
  input isolate_pkg::cnt_t   cnt_i,
  input logic                fire_i,
  input logic                done_i,
  input logic                mst_valid_i,
  input logic                isolated_i
);

  import isolate_pkg::*;

  // Open transactions stay within the limit
  cnt_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_i <= cnt_t'(NumPending))
    else $error("pending counter above limit");

  // A completion without a forward in the same cycle needs an open transaction
  cnt_no_wrap: assert property (@(posedge clk_i) disable iff (rst_i)
    (done_i && !fire_i) |-> (cnt_i != '0))
    else $error("completion with no open transaction wraps the counter");

  // Nothing reaches the subordinate and nothing is left open once isolated
  isolated_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    isolated_i |-> (!mst_valid_i && (cnt_i == '0)))
    else $error("master valid or open transaction while isolated");

endmodule

bind isolate_chan_ctrl axi_isolate_asserts u_asserts (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .cnt_i       ( cnt_q       ),
  .fire_i      ( fire_o      ),
  .done_i      ( done_i      ),
  .mst_valid_i ( mst_valid_o ),
  .isolated_i  ( isolated_o  )
);

`default_nettype wire

//--- tb_axi_isolate.sv
// Directed testbench for the AXI4 isolation stage.
// Drives both bundles on falling edges and checks pass-through, hold, limits and drain.
`timescale 1ns/1ps
`default_nettype none

module tb_axi_isolate;

  import axi_chan_pkg::*;
  import isolate_pkg::*;

  localparam int unsigned clk_period  = 8;
  // Rough sum of all test lengths in cycles, plus slack
  localparam int unsigned test_cycles = 60;
  localparam int unsigned margin      = 40;
  localparam int unsigned timeout_ns  = (test_cycles + margin) * clk_period;

  logic     clk;
  logic     rst;
  logic     isolate;
  logic     isolated;
  axi_req_t slv_req;
  axi_rsp_t slv_rsp;
  axi_req_t mst_req;
  axi_rsp_t mst_rsp;
  integer   seed = 24310;
  int       errors = 0;

  axi_isolate UUT (
    .clk_i      ( clk      ),
    .rst_i      ( rst      ),
    .isolate_i  ( isolate  ),
    .isolated_o ( isolated ),
    .slv_req_i  ( slv_req  ),
    .slv_rsp_o  ( slv_rsp  ),
    .mst_req_o  ( mst_req  ),
    .mst_rsp_i  ( mst_rsp  )
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // Random id, addr and len in address channel layout
  function automatic logic [$bits(aw_chan_t)-1:0] rand_addr_chan();
    logic [31:0] r;
    r = rand_word();
    return {r[3:0], rand_word(), r[15:8]};
  endfunction

  task automatic fail_bit(input string test, input string what, input logic exp,
                          input logic act);
    $display("FAIL %s: %s expected %b, actual %b", test, what, exp, act);
    errors++;
  endtask

  task automatic fail_vec(input string test, input string what, input logic [159:0] exp,
                          input logic [159:0] act);
    $display("FAIL %s: %s expected %h, actual %h", test, what, exp, act);
    errors++;
  endtask

  task automatic drive_idle();
    slv_req = '0;
    mst_rsp = '0;
  endtask

  // Every valid and ready high, last set, so each channel completes in one cycle
  task automatic offer_all();
    logic [31:0] r;
    r = rand_word();
    slv_req.aw       = rand_addr_chan();
    slv_req.aw_valid = 1'b1;
    slv_req.w        = {rand_word(), 1'b1};
    slv_req.w_valid  = 1'b1;
    slv_req.b_ready  = 1'b1;
    slv_req.ar       = rand_addr_chan();
    slv_req.ar_valid = 1'b1;
    slv_req.r_ready  = 1'b1;
    mst_rsp.aw_ready = 1'b1;
    mst_rsp.w_ready  = 1'b1;
    mst_rsp.b        = r[5:0];
    mst_rsp.b_valid  = 1'b1;
    mst_rsp.ar_ready = 1'b1;
    mst_rsp.r        = {r[11:8], rand_word(), r[13:12], 1'b1};
    mst_rsp.r_valid  = 1'b1;
  endtask

  // Last W beat then B for one open write
  task automatic complete_write(input string test);
    @(negedge clk);
    drive_idle();
    slv_req.w       = {rand_word(), 1'b1};
    slv_req.w_valid = 1'b1;
    mst_rsp.w_ready = 1'b1;
    #1;
    if (mst_req.w_valid !== 1'b1) fail_bit(test, "owed W valid", 1'b1, mst_req.w_valid);
    @(negedge clk);
    drive_idle();
    mst_rsp.b_valid = 1'b1;
    slv_req.b_ready = 1'b1;
    #1;
    if (slv_rsp.b_valid !== 1'b1) fail_bit(test, "B valid", 1'b1, slv_rsp.b_valid);
    @(negedge clk);
    drive_idle();
  endtask

  // One R beat with last per open read
  task automatic complete_reads(input string test, input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      drive_idle();
      mst_rsp.r       = {4'h0, rand_word(), 2'b00, 1'b1};
      mst_rsp.r_valid = 1'b1;
      slv_req.r_ready = 1'b1;
      #1;
      if (slv_rsp.r_valid !== 1'b1) fail_bit(test, "R valid", 1'b1, slv_rsp.r_valid);
    end
    @(negedge clk);
    drive_idle();
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    // Traffic on all channels must not leak while isolated
    @(negedge clk);
    offer_all();
    #1;
    if (isolated !== 1'b1) fail_bit("reset_state", "isolated_o", 1'b1, isolated);
    if ({mst_req.aw_valid, mst_req.w_valid, mst_req.ar_valid, mst_req.b_ready,
         mst_req.r_ready} !== 5'b0)
      fail_vec("reset_state", "master valids", 160'(0),
               160'({mst_req.aw_valid, mst_req.w_valid, mst_req.ar_valid,
                     mst_req.b_ready, mst_req.r_ready}));
    if ({slv_rsp.aw_ready, slv_rsp.w_ready, slv_rsp.ar_ready, slv_rsp.b_valid,
         slv_rsp.r_valid} !== 5'b0)
      fail_vec("reset_state", "slave readies", 160'(0),
               160'({slv_rsp.aw_ready, slv_rsp.w_ready, slv_rsp.ar_ready,
                     slv_rsp.b_valid, slv_rsp.r_valid}));
    @(negedge clk);
    drive_idle();
    isolate = 1'b0;
    #1;
    if (isolated !== 1'b1) fail_bit("reset_state", "isolated_o before edge", 1'b1, isolated);
    @(negedge clk);
    #1;
    if (isolated !== 1'b0) fail_bit("reset_state", "isolated_o after edge", 1'b0, isolated);
  endtask

  task automatic test_pass_through();
    repeat (8) begin
      @(negedge clk);
      offer_all();
      #1;
      if (mst_req !== slv_req) fail_vec("pass_through", "mst_req", 160'(slv_req), 160'(mst_req));
      if (slv_rsp !== mst_rsp) fail_vec("pass_through", "slv_rsp", 160'(mst_rsp), 160'(slv_rsp));
    end
    @(negedge clk);
    drive_idle();
  endtask

  task automatic test_hold();
    @(negedge clk);
    slv_req.aw       = rand_addr_chan();
    slv_req.aw_valid = 1'b1;
    #1;
    if (mst_req.aw !== slv_req.aw) fail_vec("hold", "mst aw", 160'(slv_req.aw), 160'(mst_req.aw));
    if (mst_req.aw_valid !== 1'b1) fail_bit("hold", "mst aw_valid", 1'b1, mst_req.aw_valid);
    // Manager withdraws, master side must keep valid
    @(negedge clk);
    drive_idle();
    repeat (2) begin
      #1;
      if (mst_req.aw_valid !== 1'b1) fail_bit("hold", "held aw_valid", 1'b1, mst_req.aw_valid);
      @(negedge clk);
    end
    mst_rsp.aw_ready = 1'b1;
    #1;
    if (mst_req.aw_valid !== 1'b1) fail_bit("hold", "aw_valid at ready", 1'b1, mst_req.aw_valid);
    @(negedge clk);
    mst_rsp.aw_ready = 1'b0;
    #1;
    if (mst_req.aw_valid !== 1'b0) fail_bit("hold", "aw_valid after", 1'b0, mst_req.aw_valid);
    complete_write("hold");
  endtask

  task automatic test_w_gating();
    @(negedge clk);
    drive_idle();
    slv_req.w       = {rand_word(), 1'b1};
    slv_req.w_valid = 1'b1;
    mst_rsp.w_ready = 1'b1;
    #1;
    if (mst_req.w_valid !== 1'b0) fail_bit("w_gating", "mst w_valid", 1'b0, mst_req.w_valid);
    if (slv_rsp.w_ready !== 1'b0) fail_bit("w_gating", "slv w_ready", 1'b0, slv_rsp.w_ready);
    if (mst_req.w !== '0) fail_vec("w_gating", "mst w", 160'(0), 160'(mst_req.w));
  endtask

  task automatic test_read_limit();
    repeat (NumPending) begin
      @(negedge clk);
      drive_idle();
      slv_req.ar       = rand_addr_chan();
      slv_req.ar_valid = 1'b1;
      mst_rsp.ar_ready = 1'b1;
      #1;
      if (mst_req.ar_valid !== 1'b1) fail_bit("read_limit", "ar_valid", 1'b1, mst_req.ar_valid);
    end
    @(negedge clk);
    slv_req.ar = rand_addr_chan();
    #1;
    if (mst_req.ar_valid !== 1'b0) fail_bit("read_limit", "blocked ar_valid", 1'b0, mst_req.ar_valid);
    if (slv_rsp.ar_ready !== 1'b0) fail_bit("read_limit", "blocked ar_ready", 1'b0, slv_rsp.ar_ready);
    // One completion frees a slot at the next edge
    @(negedge clk);
    mst_rsp.r       = {4'h0, rand_word(), 2'b00, 1'b1};
    mst_rsp.r_valid = 1'b1;
    slv_req.r_ready = 1'b1;
    #1;
    if (mst_req.ar_valid !== 1'b0) fail_bit("read_limit", "ar_valid at R", 1'b0, mst_req.ar_valid);
    @(negedge clk);
    mst_rsp.r_valid = 1'b0;
    slv_req.r_ready = 1'b0;
    #1;
    if (mst_req.ar_valid !== 1'b1) fail_bit("read_limit", "freed ar_valid", 1'b1, mst_req.ar_valid);
    if (slv_rsp.ar_ready !== 1'b1) fail_bit("read_limit", "freed ar_ready", 1'b1, slv_rsp.ar_ready);
    complete_reads("read_limit", NumPending);
  endtask

  task automatic test_drain();
    @(negedge clk);
    drive_idle();
    slv_req.aw       = rand_addr_chan();
    slv_req.aw_valid = 1'b1;
    mst_rsp.aw_ready = 1'b1;
    slv_req.ar       = rand_addr_chan();
    slv_req.ar_valid = 1'b1;
    mst_rsp.ar_ready = 1'b1;
    @(negedge clk);
    drive_idle();
    isolate = 1'b1;
    // Both paths in DRAIN from here, new AW held off
    @(negedge clk);
    slv_req.aw       = rand_addr_chan();
    slv_req.aw_valid = 1'b1;
    mst_rsp.aw_ready = 1'b1;
    #1;
    if (mst_req.aw_valid !== 1'b0) fail_bit("drain", "aw_valid in drain", 1'b0, mst_req.aw_valid);
    if (isolated !== 1'b0) fail_bit("drain", "isolated_o early", 1'b0, isolated);
    complete_write("drain");
    // Final R is the later completion
    mst_rsp.r       = {4'h0, rand_word(), 2'b00, 1'b1};
    mst_rsp.r_valid = 1'b1;
    slv_req.r_ready = 1'b1;
    #1;
    if (isolated !== 1'b0) fail_bit("drain", "isolated_o at R", 1'b0, isolated);
    @(negedge clk);
    drive_idle();
    #1;
    if (isolated !== 1'b0) fail_bit("drain", "isolated_o one edge", 1'b0, isolated);
    @(negedge clk);
    #1;
    if (isolated !== 1'b1) fail_bit("drain", "isolated_o two edges", 1'b1, isolated);
    slv_req.aw       = rand_addr_chan();
    slv_req.aw_valid = 1'b1;
    mst_rsp.aw_ready = 1'b1;
    mst_rsp.b_valid  = 1'b1;
    #1;
    if (slv_rsp.aw_ready !== 1'b0) fail_bit("drain", "slv aw_ready", 1'b0, slv_rsp.aw_ready);
    if (mst_req.aw_valid !== 1'b0) fail_bit("drain", "mst aw_valid", 1'b0, mst_req.aw_valid);
    if (mst_req.aw !== '0) fail_vec("drain", "mst aw", 160'(0), 160'(mst_req.aw));
    if (slv_rsp.b_valid !== 1'b0) fail_bit("drain", "slv b_valid", 1'b0, slv_rsp.b_valid);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    isolate = 1'b1;
    drive_idle();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_pass_through();
    test_hold();
    test_w_gating();
    test_read_limit();
    test_drain();
    $display("Run complete, %0d error(s)", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_isolate.f
axi_chan_pkg.sv
isolate_pkg.sv
isolate_chan_ctrl.sv
isolate_w_tracker.sv
axi_isolate.sv
axi_isolate_asserts.sv
tb_axi_isolate.sv

//--- run.sh
#!/bin/sh
# Build and run the isolation stage testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_isolate -f axi_isolate.f --Mdir "$BUILD_DIR" -o sim_axi_isolate
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_axi_isolate" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
